/* coco_reset_top.f */
src/coco_cfg_pkg.sv
src/coco_rst_pkg.sv
src/config_watch.sv
src/rom_load_track.sv
src/reset_combine.sv
src/coco_reset_top.sv
bench/coco_reset_properties.sv
bench/tb_coco_reset.sv

/* Makefile */
# Verilator simulation of the reset sequencing block

VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_coco_reset
FILELIST  = coco_reset_top.f
OBJ_DIR   = obj_dir
SIM_LOG   = sim.log
PASS_MSG  = NO ERRORS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides the result, so a crash or an assertion stop also fails
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(SIM_LOG) 2>&1 || true
	@cat $(SIM_LOG)
	@grep -qx "$(PASS_MSG)" $(SIM_LOG) || (echo "simulation failed"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)

/* bench/tb_coco_reset.sv */
// Reset sequencing testbench
`timescale 1ns/1ps
`default_nettype none

module tb_coco_reset;

	import coco_cfg_pkg::*;
	import coco_rst_pkg::*;

	localparam int HOLD_CYCLES = 40;
	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 4;

	// Rough sum of the test lengths in clock cycles, with margin
	localparam int RUN_CYCLES = 6 * 40 + 3 * HOLD_CYCLES + 200;

	// State of the cycle model
	typedef struct packed {
		logic         primed;
		machine_cfg_t cfg_copy;
		logic [15:0]  busy_left;
		logic         dl_q;
		logic         loaded;
		logic         hard;
		logic         core;
	} model_t;

	logic        clk57 = 1'b0;
	logic        arst_n;
	osd_status_t status;
	logic        button;
	logic        download;
	rst_state_t  rst;
	model_t      model_q;
	int          checks;
	int          errors;
	logic [31:0] lfsr_q = 32'h7f9a;

	always #(CLK_PERIOD / 2) clk57 = ~clk57;

	coco_reset_top #(
		.HOLD_CYCLES (HOLD_CYCLES)
	) u_dut (
		.clk57            (clk57),
		.arst_n_i         (arst_n),
		.status_i         (status),
		.button_reset_i   (button),
		.ioctl_download_i (download),
		.rst_o            (rst)
	);

	// ==============================
	// Random bits and reference model
	// ==============================

	// Taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_step(lfsr_q);
			v = {v[30:0], lfsr_q[0]};
		end
	endtask

	function automatic model_t reset_model();
		model_t m;
		m = '0;
		m.hard = 1'b1;
		m.core = 1'b1;
		return m;
	endfunction

	// One rising edge of the reset rules; returns the outputs after that edge
	function automatic rst_state_t predict_next(
		input  model_t      cur,
		input  osd_status_t st,
		input  logic        btn,
		input  logic        dl,
		output model_t      nxt
	);
		logic       busy;
		logic       changed;
		rst_state_t exp_rst;
		busy = (cur.busy_left != '0);
		changed = cur.primed && (st.cfg != cur.cfg_copy);
		nxt = cur;
		nxt.primed = 1'b1;
		nxt.cfg_copy = st.cfg;
		if (changed) begin
			nxt.busy_left = 16'(HOLD_CYCLES);
		end else if (busy) begin
			nxt.busy_left = cur.busy_left - 16'd1;
		end
		nxt.dl_q = dl;
		nxt.loaded = cur.loaded || (cur.dl_q && !dl);
		nxt.hard = st.hard_req || st.cart_remove || dl || busy;
		nxt.core = cur.hard || st.soft_req || btn || !cur.loaded;
		exp_rst.hard_reset = nxt.hard;
		exp_rst.core_reset = nxt.core;
		exp_rst.rom_loaded = nxt.loaded;
		return exp_rst;
	endfunction

	task automatic check_rst(input rst_state_t exp_rst);
		checks++;
		if (rst !== exp_rst) begin
			errors++;
			$display("error at %0d ns: hard/core/loaded expected %b%b%b, got %b%b%b", $time,
				exp_rst.hard_reset, exp_rst.core_reset, exp_rst.rom_loaded,
				rst.hard_reset, rst.core_reset, rst.rom_loaded);
		end
	endtask

	task automatic expect_bit(input logic actual, input logic expected, input string what);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("error at %0d ns: %s is %b, expected %b", $time, what, actual, expected);
		end
	endtask

	// Model and DUT are compared just after every rising edge out of reset
	always @(posedge clk57) begin : compare_outputs
		rst_state_t exp_rst;
		model_t     nxt;
		if (!arst_n) begin
			model_q <= reset_model();
		end else begin
			exp_rst = predict_next(model_q, status, button, download, nxt);
			model_q <= nxt;
			#1;
			check_rst(exp_rst);
		end
	end

	// ==============================
	// Tests
	// ==============================

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk57);
	endtask

	task automatic report_test(input int num, input string name, input int err_before);
		if (errors == err_before) begin
			$display("test %0d %s: passed", num, name);
		end else begin
			$display("test %0d %s: failed with %0d mismatches", num, name, errors - err_before);
		end
	endtask

	task automatic apply_reset(input machine_cfg_t cfg_after);
		@(negedge clk57);
		arst_n = 1'b0;
		wait_cycles(RESET_CYCLES);
		expect_bit(rst.hard_reset, 1'b1, "hard_reset in reset");
		expect_bit(rst.core_reset, 1'b1, "core_reset in reset");
		expect_bit(rst.rom_loaded, 1'b0, "rom_loaded in reset");
		arst_n = 1'b1;
		status.cfg = cfg_after;
	endtask

	// Counts the cycles with hard_reset high; a second change can be made on the way
	task automatic count_hard_cycles(input int second_after, output int len);
		len = 0;
		for (int i = 1; i < 3 * HOLD_CYCLES; i++) begin
			@(negedge clk57);
			if (rst.hard_reset) begin
				len++;
			end else if (len > 0) begin
				break;
			end
			if (i == second_after) begin
				status.cfg.mem64kb = ~status.cfg.mem64kb;
			end
		end
	endtask

	task automatic pulse_core_source(input logic use_button, input int len, input string what);
		expect_bit(rst.core_reset, 1'b0, "core_reset before request");
		if (use_button) button = 1'b1;
		else status.soft_req = 1'b1;
		@(negedge clk57);
		expect_bit(rst.core_reset, 1'b1, what);
		expect_bit(rst.hard_reset, 1'b0, "hard_reset during core request");
		wait_cycles(len - 1);
		button = 1'b0;
		status.soft_req = 1'b0;
		wait_cycles(2);
	endtask

	task automatic pulse_hard_source(input logic use_cart);
		if (use_cart) status.cart_remove = 1'b1;
		else status.hard_req = 1'b1;
		@(negedge clk57);
		expect_bit(rst.hard_reset, 1'b1, "hard_reset one cycle after request");
		expect_bit(rst.core_reset, 1'b0, "core_reset one cycle after request");
		@(negedge clk57);
		expect_bit(rst.core_reset, 1'b1, "core_reset two cycles after request");
		wait_cycles(3);
		status.cart_remove = 1'b0;
		status.hard_req = 1'b0;
		wait_cycles(4);
	endtask

	initial begin : run_tests
		int          err_before;
		int          len;
		logic [31:0] v;
		arst_n = 1'b0;
		status = '0;
		button = 1'b0;
		download = 1'b0;
		checks = 0;
		errors = 0;

		err_before = errors;
		apply_reset('0);
		wait_cycles(10);
		expect_bit(rst.hard_reset, 1'b0, "hard_reset after reset");
		expect_bit(rst.core_reset, 1'b1, "core_reset without a ROM");
		expect_bit(rst.rom_loaded, 1'b0, "rom_loaded without a download");
		report_test(1, "reset state", err_before);

		err_before = errors;
		download = 1'b1;
		@(negedge clk57);
		expect_bit(rst.hard_reset, 1'b1, "hard_reset during download");
		wait_cycles(5);
		download = 1'b0;
		@(negedge clk57);
		expect_bit(rst.hard_reset, 1'b0, "hard_reset after download");
		expect_bit(rst.rom_loaded, 1'b1, "rom_loaded after download");
		expect_bit(rst.core_reset, 1'b1, "core_reset one cycle after download");
		@(negedge clk57);
		expect_bit(rst.core_reset, 1'b0, "core_reset two cycles after download");
		wait_cycles(2);
		report_test(2, "rom download", err_before);

		err_before = errors;
		pulse_core_source(1'b0, 3, "core_reset after soft_req");
		for (int k = 0; k < 4; k++) begin
			draw_bits(3, v);
			wait_cycles(int'(v[2:0]) + 1);
			draw_bits(3, v);
			pulse_core_source(1'b1, int'(v[2:0]) + 1, "core_reset after button");
		end
		report_test(3, "soft request and button", err_before);

		err_before = errors;
		pulse_hard_source(1'b0);
		pulse_hard_source(1'b1);
		report_test(4, "hard request and cart removal", err_before);

		err_before = errors;
		status.cfg.dragon = 1'b1;
		count_hard_cycles(0, len);
		if (len != HOLD_CYCLES) begin
			errors++;
			$display("error at %0d ns: hard_reset held %0d cycles, expected %0d", $time, len,
				HOLD_CYCLES);
		end
		wait_cycles(3);
		status.cfg.mem64kb = 1'b1;
		count_hard_cycles(15, len);
		if (len != HOLD_CYCLES + 15) begin
			errors++;
			$display("error at %0d ns: extended hold was %0d cycles, expected %0d", $time, len,
				HOLD_CYCLES + 15);
		end
		wait_cycles(3);
		for (int k = 0; k < 24; k++) begin
			draw_bits(VIDEO_OPT_W, v);
			status.video_opts = v[VIDEO_OPT_W-1:0];
			draw_bits(OTHER_OPT_W, v);
			status.other_opts = v[OTHER_OPT_W-1:0];
			status.cfg = status.cfg;
			@(negedge clk57);
			expect_bit(rst.hard_reset, 1'b0, "hard_reset after option change");
		end
		report_test(5, "configuration change", err_before);

		err_before = errors;
		status = '0;
		apply_reset('{mem64kb: 1'b1, dragon: 1'b1});
		@(negedge clk57);
		for (int k = 0; k < 10; k++) begin
			expect_bit(rst.hard_reset, 1'b0, "hard_reset after first cfg");
			@(negedge clk57);
		end
		report_test(6, "first configuration", err_before);

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	initial begin : watchdog
		#(RUN_CYCLES * CLK_PERIOD);
		$display("timeout: the tests did not finish within %0d clock cycles", RUN_CYCLES);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

/* bench/coco_reset_properties.sv */
// Reset ordering assertions
`timescale 1ns/1ps
`default_nettype none

module coco_reset_properties (
	input wire                      clk57,
	input wire                      arst_n_i,
	input coco_rst_pkg::rst_state_t rst_i
);

	// ==============================
	// Reset ordering
	// ==============================

	// The CPU never runs in the cycle right after a hard reset
	core_follows_hard: assert property (
		@(posedge clk57) disable iff (!arst_n_i)
		$past(rst_i.hard_reset) |-> rst_i.core_reset
	) else $error("core_reset low one cycle after hard_reset was high");

	// Both resets are still asserted on the first edge after release
	release_state: assert property (
		@(posedge clk57)
		$rose(arst_n_i) |-> (rst_i.hard_reset && rst_i.core_reset)
	) else $error("resets not both high on the first edge after reset release");

	// Only the asynchronous reset may clear the loaded flag
	rom_loaded_sticky: assert property (
		@(posedge clk57) disable iff (!arst_n_i)
		$past(rst_i.rom_loaded) |-> rst_i.rom_loaded
	) else $error("rom_loaded fell without a reset");

endmodule

bind reset_combine coco_reset_properties u_reset_properties (
	.clk57    (clk57),
	.arst_n_i (arst_n_i),
	.rst_i    (rst_o)
);

`default_nettype wire

/* src/coco_reset_top.sv */
// Reset sequencing top level
`timescale 1ns/1ps
`default_nettype none

module coco_reset_top #(
	parameter int unsigned HOLD_CYCLES = 65535
) (
	input  wire                        clk57,
	input  wire                        arst_n_i,
	input  coco_cfg_pkg::osd_status_t  status_i,
	input  logic                       button_reset_i,
	input  logic                       ioctl_download_i,
	output coco_rst_pkg::rst_state_t   rst_o
);

	import coco_cfg_pkg::*;
	import coco_rst_pkg::*;

	machine_cfg_t cfg;
	reset_req_t   req;
	logic         cfg_busy;
	logic         rom_loaded;

	// ==============================
	// Menu word split
	// ==============================

	assign cfg = status_i.cfg;

	// Direct requests, together with the button and the download level
	assign req.hard_req    = status_i.hard_req;
	assign req.soft_req    = status_i.soft_req;
	assign req.cart_remove = status_i.cart_remove;
	assign req.button      = button_reset_i;
	assign req.download    = ioctl_download_i;

	// ==============================
	// Reset sources
	// ==============================

	config_watch #(
		.HOLD_CYCLES (HOLD_CYCLES)
	) u_config_watch (
		.clk57      (clk57),
		.arst_n_i   (arst_n_i),
		.cfg_i      (cfg),
		.cfg_busy_o (cfg_busy)
	);

	rom_load_track u_rom_load_track (
		.clk57        (clk57),
		.arst_n_i     (arst_n_i),
		.download_i   (ioctl_download_i),
		.rom_loaded_o (rom_loaded)
	);

	// Final registered resets
	reset_combine u_reset_combine (
		.clk57        (clk57),
		.arst_n_i     (arst_n_i),
		.req_i        (req),
		.cfg_busy_i   (cfg_busy),
		.rom_loaded_i (rom_loaded),
		.rst_o        (rst_o)
	);

endmodule

`default_nettype wire

/* src/reset_combine.sv */
// Hard and core reset combiner
`timescale 1ns/1ps
`default_nettype none

module reset_combine (
	input  wire                       clk57,
	input  wire                       arst_n_i,
	input  coco_rst_pkg::reset_req_t  req_i,
	input  logic                      cfg_busy_i,
	input  logic                      rom_loaded_i,
	output coco_rst_pkg::rst_state_t  rst_o
);

	logic hard_term;
	logic core_term;
	logic hard_q;
	logic core_q;

	// ==============================
	// Reset terms
	// ==============================

	// Anything that changes memory contents or machine layout needs a hard reset
	assign hard_term = req_i.hard_req
		|| req_i.cart_remove
		|| req_i.download
		|| cfg_busy_i;

	// The CPU stays held until a system ROM exists.
	// Using the registered hard reset keeps the core one cycle behind it.
	assign core_term = hard_q
		|| req_i.soft_req
		|| req_i.button
		|| !rom_loaded_i;

	// ==============================
	// Output registers
	// ==============================

	// Both resets come out of power-up asserted
	always_ff @(posedge clk57 or negedge arst_n_i) begin
		if (!arst_n_i) begin
			hard_q <= 1'b1;
			core_q <= 1'b1;
		end else begin
			hard_q <= hard_term;
			core_q <= core_term;
		end
	end

	assign rst_o.hard_reset = hard_q;
	assign rst_o.core_reset = core_q;
	assign rst_o.rom_loaded = rom_loaded_i;

endmodule

`default_nettype wire

/* src/rom_load_track.sv */
// System ROM load tracker
`timescale 1ns/1ps
`default_nettype none

module rom_load_track (
	input  wire  clk57,
	input  wire  arst_n_i,
	input  logic download_i,
	output logic rom_loaded_o
);

	logic download_q;
	logic download_done;
	logic loaded_q;

	// Delayed copy of the download level for edge detection
	always_ff @(posedge clk57 or negedge arst_n_i) begin
		if (!arst_n_i) begin
			download_q <= 1'b0;
		end else begin
			download_q <= download_i;
		end
	end

	// A download has just ended when the old level is high and the new one low
	assign download_done = download_q && !download_i;

	// ==============================
	// Sticky loaded flag
	// ==============================

	// Once set, only the asynchronous reset brings the flag back down
	always_ff @(posedge clk57 or negedge arst_n_i) begin
		if (!arst_n_i) begin
			loaded_q <= 1'b0;
		end else if (download_done) begin
			loaded_q <= 1'b1;
		end
	end

	assign rom_loaded_o = loaded_q;

endmodule

`default_nettype wire

/* src/config_watch.sv */
// Machine configuration watcher
`timescale 1ns/1ps
`default_nettype none

module config_watch #(
	parameter int unsigned HOLD_CYCLES = 65535
) (
	input  wire                        clk57,
	input  wire                        arst_n_i,
	input  coco_cfg_pkg::machine_cfg_t cfg_i,
	output logic                       cfg_busy_o
);

	import coco_cfg_pkg::*;

	localparam int HOLD_W = $clog2(HOLD_CYCLES + 1);

	logic              primed_q;
	machine_cfg_t      cfg_q;
	logic              cfg_change;
	logic [HOLD_W-1:0] cnt_q;
	logic [HOLD_W-1:0] cnt_d;
	logic              busy_q;

	// ==============================
	// Change detection
	// ==============================

	// The copy simply follows the input, so a change shows for one sample only
	always_ff @(posedge clk57) begin
		cfg_q <= cfg_i;
	end

	// Nothing is compared until the first value after reset has been stored
	always_ff @(posedge clk57 or negedge arst_n_i) begin
		if (!arst_n_i) begin
			primed_q <= 1'b0;
		end else begin
			primed_q <= 1'b1;
		end
	end

	assign cfg_change = primed_q && (cfg_i != cfg_q);

	// ==============================
	// Settle countdown
	// ==============================

	// The count runs one below the hold length since the busy flag
	// is itself registered and adds the missing cycle
	always_comb begin
		cnt_d = cnt_q;
		if (cfg_change) begin
			cnt_d = HOLD_W'(HOLD_CYCLES - 1);
		end else if (cnt_q != '0) begin
			cnt_d = cnt_q - 1'b1;
		end
	end

	always_ff @(posedge clk57 or negedge arst_n_i) begin
		if (!arst_n_i) begin
			cnt_q  <= '0;
			busy_q <= 1'b0;
		end else begin
			cnt_q  <= cnt_d;
			busy_q <= cfg_change || (cnt_q != '0);
		end
	end

	assign cfg_busy_o = busy_q;

endmodule

`default_nettype wire

/* src/coco_rst_pkg.sv */
// Reset requests and reset state
`default_nettype none

package coco_rst_pkg;

	// Direct requests that reach the reset registers without a countdown
	typedef struct packed {
		logic hard_req;
		logic soft_req;
		logic cart_remove;
		logic button;
		logic download;
	} reset_req_t;

	// ==============================
	// Output bundle
	// ==============================

	// Hard reset clears machine state and memory setup.
	// Core reset only restarts the CPU.
	typedef struct packed {
		logic hard_reset;
		logic core_reset;
		logic rom_loaded;
	} rst_state_t;

endpackage

`default_nettype wire

/* src/coco_cfg_pkg.sv */
// Menu status and machine configuration
`default_nettype none

package coco_cfg_pkg;

	// ==============================
	// Field widths of the menu word
	// ==============================

	localparam int OSD_STATUS_W = 32;
	localparam int VIDEO_OPT_W = 6;
	localparam int MACHINE_CFG_W = 2;

	// Options above bit 10 are not looked at by the reset logic
	localparam int OTHER_OPT_W = OSD_STATUS_W - MACHINE_CFG_W - VIDEO_OPT_W - 3;

	// Settings whose change needs a full machine restart
	typedef struct packed {
		logic mem64kb;
		logic dragon;
	} machine_cfg_t;

	// Layout of the 32-bit status word from the on-screen menu.
	// Bit 0 sits at the bottom of the struct.
	typedef struct packed {
		logic [OTHER_OPT_W-1:0] other_opts;
		machine_cfg_t           cfg;
		logic [VIDEO_OPT_W-1:0] video_opts;
		logic                   cart_remove;
		logic                   soft_req;
		logic                   hard_req;
	} osd_status_t;

endpackage

`default_nettype wire
